/* rtl/addr_decode.sv */
`timescale 1ns/100ps
`include "soc_misc_consts.svh"

module addr_decode (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   req_valid_i,
	input  soc_misc_pkg::bus_req_t req_i,
	output logic                   dec_valid_o,
	output soc_misc_pkg::dec_req_t dec_o
);
	import soc_misc_pkg::*;

	region_t  region;
	reg_idx_t idx;

	// region nibble on top, word index in bits 6:2
	assign region = req_i.addr[31:28];
	assign idx    = req_i.addr[6:2];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= req_valid_i;
		end
	end

	always_ff @(posedge clk48m) begin
		if (req_valid_i) begin
			dec_o.idx   <= idx;
			// only strobe bit 0 marks a write
			dec_o.write <= req_i.strb[0];
			// anything outside the misc region is a bus error
			dec_o.err   <= (region != `MISC_REGION);
			dec_o.wdata <= req_i.wdata;
		end
	end

endmodule

/* rtl/bus_slave_port.sv */
`timescale 1ns/100ps

module bus_slave_port (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   req_i,
	input  soc_misc_pkg::bus_req_t req_data_i,
	output logic                   ack_o,
	output soc_misc_pkg::bus_rsp_t rsp_o,
	output logic                   req_valid_o,
	output soc_misc_pkg::bus_req_t req_o,
	input  logic                   rsp_valid_i,
	input  soc_misc_pkg::bus_rsp_t rsp_i
);
	import soc_misc_pkg::*;

	port_state_t state;

	// ------------------------------
	// handshake FSM
	// ------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			state <= port_idle;
			req_valid_o <= 1'b0;
		end else begin
			req_valid_o <= 1'b0;
			case (state)
				port_idle: begin
					// take the request once, the master keeps req_i up until ack
					if (req_i) begin
						req_valid_o <= 1'b1;
						state <= port_busy;
					end
				end
				port_busy: begin
					if (rsp_valid_i) begin
						state <= port_ack;
					end
				end
				port_ack: begin
					// hold ack until the master lets go of req_i
					if (!req_i) begin
						state <= port_idle;
					end
				end
				default: begin
					state <= port_idle;
				end
			endcase
		end
	end

	// ------------------------------
	// payload capture
	// ------------------------------
	always_ff @(posedge clk48m) begin
		if (state == port_idle && req_i) begin
			req_o <= req_data_i;
		end
		// response stays stable for as long as ack is high
		if (state == port_busy && rsp_valid_i) begin
			rsp_o <= rsp_i;
		end
	end

	assign ack_o = (state == port_ack);

endmodule

/* rtl/flash_reload_seq.sv */
`timescale 1ns/100ps
`include "soc_misc_consts.svh"

module flash_reload_seq (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_strobe_i,
	input  logic reload_req_i,
	output logic fsel_c_o,
	output logic programn_o
);

	logic [2:0] fsel_cnt;
	logic       reload_q;

	// ------------------------------
	// countdown
	// ------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_cnt <= 3'd0;
		end else if (fsel_strobe_i) begin
			// a new strobe restarts the whole sequence
			fsel_cnt <= `FSEL_DELAY_START;
		end else if (fsel_cnt != 3'd0) begin
			fsel_cnt <= fsel_cnt - 3'd1;
		end
	end

	// clock the flash-mux flop in the middle of the countdown so fsel_d is settled
	assign fsel_c_o = (fsel_cnt <= `FSEL_PULSE_HI) && (fsel_cnt >= `FSEL_PULSE_LO);

	// ------------------------------
	// reconfiguration request
	// ------------------------------
	// programn is pulled as the mux clock pulse ends, so the new flash
	// is already selected when the FPGA starts to reload
	always_ff @(posedge clk48m) begin
		if (rst) begin
			reload_q <= 1'b0;
		end else if (reload_req_i && fsel_cnt == `FSEL_PULSE_LO) begin
			reload_q <= 1'b1;
		end
	end

	// active low, held until reset
	assign programn_o = ~reload_q;

endmodule

/* rtl/misc_regs.sv */
`timescale 1ns/100ps
`include "soc_misc_consts.svh"

module misc_regs (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   dec_valid_i,
	input  soc_misc_pkg::dec_req_t dec_i,
	output logic                   rsp_valid_o,
	output soc_misc_pkg::bus_rsp_t rsp_o,
	input  logic [7:0]             btn_i,
	input  soc_misc_pkg::genio_t   genio_in_i,
	input  soc_misc_pkg::pmod_t    pmod_in_i,
	input  soc_misc_pkg::sao_t     sao1_in_i,
	input  soc_misc_pkg::sao_t     sao2_in_i,
	input  logic                   vbus_det_i,
	output soc_misc_pkg::led_t     led_o,
	output logic                   trace_en_o,
	output soc_misc_pkg::genio_t   genio_out_o,
	output soc_misc_pkg::genio_t   genio_oe_o,
	output soc_misc_pkg::pmod_t    pmod_out_o,
	output soc_misc_pkg::pmod_t    pmod_oe_o,
	output soc_misc_pkg::sao_t     sao1_out_o,
	output soc_misc_pkg::sao_t     sao1_oe_o,
	output soc_misc_pkg::sao_t     sao2_out_o,
	output soc_misc_pkg::sao_t     sao2_oe_o,
	output logic                   irda_sd_o,
	output logic                   fsel_d_o,
	output logic                   fsel_strobe_o,
	output logic                   reload_req_o
);
	import soc_misc_pkg::*;

	logic  wr_en;
	word_t rd_word;
	word_t genio_nxt;
	word_t gpext_nxt;

	// plain write, write-to-set or write-to-clear
	function automatic word_t merge_wr(input word_t cur, input word_t d,
			input logic set, input logic clr);
		if (set) begin
			return cur | d;
		end
		if (clr) begin
			return cur & ~d;
		end
		return d;
	endfunction

	// place the extension fields in their bus word positions
	function automatic word_t gpext_word(input logic b31, input logic b30,
			input pmod_t pmod, input sao_t sao2, input sao_t sao1);
		word_t w;
		w = '0;
		w[`GPEXT_VDET_BIT] = b31;
		w[`GPEXT_IRDA_BIT] = b30;
		w[`GPEXT_PMOD_LSB +: $bits(pmod_t)] = pmod;
		w[`GPEXT_SAO2_LSB +: $bits(sao_t)] = sao2;
		w[`GPEXT_SAO1_LSB +: $bits(sao_t)] = sao1;
		return w;
	endfunction

	// error accesses never touch the registers
	assign wr_en = dec_valid_i && dec_i.write && !dec_i.err;

	assign genio_nxt = merge_wr({2'b00, genio_out_o}, dec_i.wdata,
		dec_i.idx == `REG_GENIO_W2S, dec_i.idx == `REG_GENIO_W2C);
	assign gpext_nxt = merge_wr(gpext_word(1'b0, irda_sd_o, pmod_out_o, sao2_out_o, sao1_out_o),
		dec_i.wdata, dec_i.idx == `REG_GPEXT_W2S, dec_i.idx == `REG_GPEXT_W2C);

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb begin
		case (dec_i.idx)
			`REG_LED:       rd_word = {16'h0, led_o};
			// buttons are active low on the board
			`REG_BTN:       rd_word = {24'h0, ~btn_i};
			`REG_SOC_VER:   rd_word = `SOC_VERSION | {31'h0, trace_en_o};
			`REG_FLASH_SEL: rd_word = {31'h0, fsel_d_o};
			`REG_GENIO_IN:  rd_word = {2'h0, genio_in_i};
			`REG_GENIO_OUT: rd_word = {2'h0, genio_out_o};
			`REG_GENIO_OE:  rd_word = {2'h0, genio_oe_o};
			`REG_GPEXT_IN:  rd_word = gpext_word(vbus_det_i, 1'b0, pmod_in_i, sao2_in_i, sao1_in_i);
			`REG_GPEXT_OUT: rd_word = gpext_word(1'b0, irda_sd_o, pmod_out_o, sao2_out_o, sao1_out_o);
			`REG_GPEXT_OE:  rd_word = gpext_word(1'b0, 1'b0, pmod_oe_o, sao2_oe_o, sao1_oe_o);
			default:        rd_word = '0;
		endcase
	end

	// ------------------------------
	// response
	// ------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= dec_valid_i;
		end
	end

	always_ff @(posedge clk48m) begin
		if (dec_valid_i) begin
			rsp_o.rdata <= dec_i.err ? `BUS_ERR_DATA : rd_word;
			rsp_o.err   <= dec_i.err;
		end
	end

	// ------------------------------
	// register writes
	// ------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_o <= '0;
			trace_en_o <= 1'b0;
			genio_out_o <= '0;
			genio_oe_o <= '0;
			pmod_out_o <= '0;
			pmod_oe_o <= '0;
			sao1_out_o <= '0;
			sao1_oe_o <= '0;
			sao2_out_o <= '0;
			sao2_oe_o <= '0;
			// IrDA transceiver stays shut down until software enables it
			irda_sd_o <= 1'b1;
			fsel_d_o <= 1'b0;
			fsel_strobe_o <= 1'b0;
			reload_req_o <= 1'b0;
		end else begin
			fsel_strobe_o <= 1'b0;
			if (wr_en) begin
				case (dec_i.idx)
					`REG_LED: begin
						led_o <= dec_i.wdata[15:0];
					end
					`REG_SOC_VER: begin
						trace_en_o <= dec_i.wdata[0];
					end
					`REG_FLASH_SEL: begin
						fsel_d_o <= dec_i.wdata[0];
						fsel_strobe_o <= 1'b1;
						// reload stays queued, the FPGA reconfigures anyway
						if (dec_i.wdata[31:8] == `RELOAD_MAGIC) begin
							reload_req_o <= 1'b1;
						end
					end
					`REG_GENIO_OUT, `REG_GENIO_W2S, `REG_GENIO_W2C: begin
						genio_out_o <= genio_nxt[29:0];
					end
					`REG_GENIO_OE: begin
						genio_oe_o <= dec_i.wdata[29:0];
					end
					`REG_GPEXT_OUT, `REG_GPEXT_W2S, `REG_GPEXT_W2C: begin
						irda_sd_o <= gpext_nxt[`GPEXT_IRDA_BIT];
						pmod_out_o <= gpext_nxt[`GPEXT_PMOD_LSB +: $bits(pmod_t)];
						sao2_out_o <= gpext_nxt[`GPEXT_SAO2_LSB +: $bits(sao_t)];
						sao1_out_o <= gpext_nxt[`GPEXT_SAO1_LSB +: $bits(sao_t)];
					end
					`REG_GPEXT_OE: begin
						pmod_oe_o <= dec_i.wdata[`GPEXT_PMOD_LSB +: $bits(pmod_t)];
						sao2_oe_o <= dec_i.wdata[`GPEXT_SAO2_LSB +: $bits(sao_t)];
						sao1_oe_o <= dec_i.wdata[`GPEXT_SAO1_LSB +: $bits(sao_t)];
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

/* rtl/soc_misc_consts.svh */
`ifndef SOC_MISC_CONSTS_SVH
`define SOC_MISC_CONSTS_SVH

// ------------------------------
// address map
// ------------------------------
// address nibble 31:28 that selects the misc block
`define MISC_REGION      4'h2

// register indices, taken from address bits 6:2
`define REG_LED          5'd0
`define REG_BTN          5'd1
`define REG_SOC_VER      5'd2
`define REG_FLASH_SEL    5'd13
`define REG_GENIO_IN     5'd17
`define REG_GENIO_OUT    5'd18
`define REG_GENIO_OE     5'd19
`define REG_GENIO_W2S    5'd20
`define REG_GENIO_W2C    5'd21
`define REG_GPEXT_IN     5'd22
`define REG_GPEXT_OUT    5'd23
`define REG_GPEXT_OE     5'd24
`define REG_GPEXT_W2S    5'd25
`define REG_GPEXT_W2C    5'd26

// ------------------------------
// extension word layout
// ------------------------------
`define GPEXT_IRDA_BIT   30
`define GPEXT_VDET_BIT   31
`define GPEXT_PMOD_LSB   16
`define GPEXT_SAO2_LSB   8
`define GPEXT_SAO1_LSB   0

// upper 24 bits of a FLASH_SEL write that also requests an FPGA reload
`define RELOAD_MAGIC     24'hD0F1A5

// flash-select sequencer counts
`define FSEL_DELAY_START 3'd7
`define FSEL_PULSE_HI    3'd5
`define FSEL_PULSE_LO    3'd3

`define SOC_VERSION      32'h0000_0000
`define BUS_ERR_DATA     32'hDEAD_BEEF

`endif

/* rtl/soc_misc_pkg.sv */
package soc_misc_pkg;

	// ------------------------------
	// widths with a meaning
	// ------------------------------
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;
	typedef logic [3:0]  region_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [15:0] led_t;
	typedef logic [29:0] genio_t;
	typedef logic [7:0]  pmod_t;
	typedef logic [5:0]  sao_t;

	// ------------------------------
	// stage payloads
	// ------------------------------
	// request as presented by the master
	typedef struct packed {
		word_t addr;
		word_t wdata;
		strb_t strb;
	} bus_req_t;

	// decoded request handed to the register file
	typedef struct packed {
		reg_idx_t idx;
		logic     write;
		logic     err;
		word_t    wdata;
	} dec_req_t;

	// response returned to the master
	typedef struct packed {
		word_t rdata;
		logic  err;
	} bus_rsp_t;

	// four-phase handshake state of the slave port
	typedef enum logic [1:0] {
		port_idle,
		port_busy,
		port_ack
	} port_state_t;

endpackage

/* rtl/soc_misc_top.sv */
`timescale 1ns/100ps

module soc_misc_top (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   req_i,
	input  soc_misc_pkg::bus_req_t req_data_i,
	output logic                   ack_o,
	output soc_misc_pkg::bus_rsp_t rsp_o,
	input  logic [7:0]             btn_i,
	input  soc_misc_pkg::genio_t   genio_in_i,
	input  soc_misc_pkg::pmod_t    pmod_in_i,
	input  soc_misc_pkg::sao_t     sao1_in_i,
	input  soc_misc_pkg::sao_t     sao2_in_i,
	input  logic                   vbus_det_i,
	output soc_misc_pkg::led_t     led_o,
	output logic                   trace_en_o,
	output soc_misc_pkg::genio_t   genio_out_o,
	output soc_misc_pkg::genio_t   genio_oe_o,
	output soc_misc_pkg::pmod_t    pmod_out_o,
	output soc_misc_pkg::pmod_t    pmod_oe_o,
	output soc_misc_pkg::sao_t     sao1_out_o,
	output soc_misc_pkg::sao_t     sao1_oe_o,
	output soc_misc_pkg::sao_t     sao2_out_o,
	output soc_misc_pkg::sao_t     sao2_oe_o,
	output logic                   irda_sd_o,
	output logic                   fsel_d_o,
	output logic                   fsel_c_o,
	output logic                   programn_o
);
	import soc_misc_pkg::*;

	logic     req_valid;
	bus_req_t req;
	logic     dec_valid;
	dec_req_t dec;
	logic     rsp_valid;
	bus_rsp_t rsp;
	logic     fsel_strobe;
	logic     reload_req;

	// capture, decode, execute, respond
	bus_slave_port u_port (
		.clk48m      (clk48m),
		.rst         (rst),
		.req_i       (req_i),
		.req_data_i  (req_data_i),
		.ack_o       (ack_o),
		.rsp_o       (rsp_o),
		.req_valid_o (req_valid),
		.req_o       (req),
		.rsp_valid_i (rsp_valid),
		.rsp_i       (rsp)
	);

	addr_decode u_decode (
		.clk48m      (clk48m),
		.rst         (rst),
		.req_valid_i (req_valid),
		.req_i       (req),
		.dec_valid_o (dec_valid),
		.dec_o       (dec)
	);

	misc_regs u_regs (
		.clk48m        (clk48m),
		.rst           (rst),
		.dec_valid_i   (dec_valid),
		.dec_i         (dec),
		.rsp_valid_o   (rsp_valid),
		.rsp_o         (rsp),
		.btn_i         (btn_i),
		.genio_in_i    (genio_in_i),
		.pmod_in_i     (pmod_in_i),
		.sao1_in_i     (sao1_in_i),
		.sao2_in_i     (sao2_in_i),
		.vbus_det_i    (vbus_det_i),
		.led_o         (led_o),
		.trace_en_o    (trace_en_o),
		.genio_out_o   (genio_out_o),
		.genio_oe_o    (genio_oe_o),
		.pmod_out_o    (pmod_out_o),
		.pmod_oe_o     (pmod_oe_o),
		.sao1_out_o    (sao1_out_o),
		.sao1_oe_o     (sao1_oe_o),
		.sao2_out_o    (sao2_out_o),
		.sao2_oe_o     (sao2_oe_o),
		.irda_sd_o     (irda_sd_o),
		.fsel_d_o      (fsel_d_o),
		.fsel_strobe_o (fsel_strobe),
		.reload_req_o  (reload_req)
	);

	flash_reload_seq u_reload (
		.clk48m        (clk48m),
		.rst           (rst),
		.fsel_strobe_i (fsel_strobe),
		.reload_req_i  (reload_req),
		.fsel_c_o      (fsel_c_o),
		.programn_o    (programn_o)
	);

endmodule

/* sim/soc_misc_asserts.sv */
`timescale 1ns/100ps

module soc_misc_asserts (
	input logic clk48m,
	input logic rst,
	input logic req_i,
	input logic ack_i,
	input logic fsel_c_i,
	input logic programn_i
);

	// read by the testbench at the end of the run
	int fail_cnt = 0;

	// ------------------------------
	// four-phase handshake
	// ------------------------------
	// req must still be up on the edge that raised ack
	ack_rise_a: assert property (@(posedge clk48m) disable iff (rst)
		$rose(ack_i) |-> $past(req_i))
		else begin
			fail_cnt++;
			$error("ack rose without a pending request");
		end

	// ack only drops once req has been seen low
	ack_fall_a: assert property (@(posedge clk48m) disable iff (rst)
		$fell(ack_i) |-> $past(!req_i))
		else begin
			fail_cnt++;
			$error("ack fell while the request was still up");
		end

	// ------------------------------
	// flash-select sequencer
	// ------------------------------
	fsel_pulse_a: assert property (@(posedge clk48m) disable iff (rst)
		$rose(fsel_c_i) |-> fsel_c_i [*3] ##1 !fsel_c_i)
		else begin
			fail_cnt++;
			$error("flash mux clock pulse is not three cycles long");
		end

	// once pulled, programn stays low until the next reset
	programn_hold_a: assert property (@(posedge clk48m) disable iff (rst)
		!$rose(programn_i))
		else begin
			fail_cnt++;
			$error("programn released without a reset");
		end

endmodule

bind soc_misc_top soc_misc_asserts u_asserts (
	.clk48m     (clk48m),
	.rst        (rst),
	.req_i      (req_i),
	.ack_i      (ack_o),
	.fsel_c_i   (fsel_c_o),
	.programn_i (programn_o)
);

/* sim/tb_soc_misc.sv */
`timescale 1ns/100ps
`include "soc_misc_consts.svh"

module tb_soc_misc;
	import soc_misc_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 8;
	localparam int N_RAND     = 40;
	localparam int N_INPUT    = 20;
	localparam int N_BUS_ERR  = 20;
	localparam int N_UNMAPPED = 12;
	localparam int N_FSEL     = 4;
	localparam int ACK_WAIT   = 16;
	// transfers issued below, and the worst-case cycles of one of them
	localparam int N_XFERS    = 10 + 4 * N_RAND + 3 * N_INPUT + N_BUS_ERR +
		2 * N_UNMAPPED + 2 * (N_FSEL + 1) + 1;
	localparam int XFER_BOUND = 2 * ACK_WAIT + 8;

	localparam word_t GPEXT_OE_MASK = (32'hFF << `GPEXT_PMOD_LSB) |
		(32'h3F << `GPEXT_SAO2_LSB) | (32'h3F << `GPEXT_SAO1_LSB);
	localparam word_t GPEXT_OUT_MASK = GPEXT_OE_MASK | (32'h1 << `GPEXT_IRDA_BIT);

	localparam reg_idx_t PLAIN_REGS [6] = '{`REG_LED, `REG_SOC_VER, `REG_GENIO_OUT,
		`REG_GENIO_OE, `REG_GPEXT_OUT, `REG_GPEXT_OE};
	localparam reg_idx_t SETCLR_REGS [4] = '{`REG_GENIO_W2S, `REG_GENIO_W2C,
		`REG_GPEXT_W2S, `REG_GPEXT_W2C};
	localparam reg_idx_t READ_REGS [10] = '{`REG_LED, `REG_BTN, `REG_SOC_VER,
		`REG_FLASH_SEL, `REG_GENIO_IN, `REG_GENIO_OUT, `REG_GENIO_OE, `REG_GPEXT_IN,
		`REG_GPEXT_OUT, `REG_GPEXT_OE};

	logic clk48m = 1'b0;
	logic rst;
	logic req_i;
	bus_req_t req_data;
	logic ack;
	bus_rsp_t rsp;
	logic [7:0] btn;
	genio_t genio_in;
	pmod_t pmod_in;
	sao_t sao1_in;
	sao_t sao2_in;
	logic vbus_det;
	led_t led;
	logic trace_en;
	genio_t genio_out;
	genio_t genio_oe;
	pmod_t pmod_out;
	pmod_t pmod_oe;
	sao_t sao1_out;
	sao_t sao1_oe;
	sao_t sao2_out;
	sao_t sao2_oe;
	logic irda_sd;
	logic fsel_d;
	logic fsel_c;
	logic programn;

	int cyc = 0;
	int xfer_start;
	int checks = 0;
	int errors = 0;

	// reference model with the extension registers in bus word layout
	led_t   m_led;
	logic   m_trace;
	logic   m_fsel_d;
	logic   m_reload;
	genio_t m_genio_out;
	genio_t m_genio_oe;
	word_t  m_gpext_out;
	word_t  m_gpext_oe;

	soc_misc_top u_dut (
		.clk48m      (clk48m),
		.rst         (rst),
		.req_i       (req_i),
		.req_data_i  (req_data),
		.ack_o       (ack),
		.rsp_o       (rsp),
		.btn_i       (btn),
		.genio_in_i  (genio_in),
		.pmod_in_i   (pmod_in),
		.sao1_in_i   (sao1_in),
		.sao2_in_i   (sao2_in),
		.vbus_det_i  (vbus_det),
		.led_o       (led),
		.trace_en_o  (trace_en),
		.genio_out_o (genio_out),
		.genio_oe_o  (genio_oe),
		.pmod_out_o  (pmod_out),
		.pmod_oe_o   (pmod_oe),
		.sao1_out_o  (sao1_out),
		.sao1_oe_o   (sao1_oe),
		.sao2_out_o  (sao2_out),
		.sao2_oe_o   (sao2_oe),
		.irda_sd_o   (irda_sd),
		.fsel_d_o    (fsel_d),
		.fsel_c_o    (fsel_c),
		.programn_o  (programn)
	);

	always #(CLK_PERIOD / 2) clk48m = ~clk48m;

	// count of rising edges seen so far
	always @(posedge clk48m) begin
		cyc <= cyc + 1;
	end

	task automatic check_val(input string name, input word_t exp, input word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic word_t model_read(input reg_idx_t idx);
		word_t w;
		w = '0;
		case (idx)
			`REG_LED:       w = {16'h0, m_led};
			`REG_BTN:       w = {24'h0, ~btn};
			`REG_SOC_VER:   w = `SOC_VERSION | {31'h0, m_trace};
			`REG_FLASH_SEL: w = {31'h0, m_fsel_d};
			`REG_GENIO_IN:  w = {2'b00, genio_in};
			`REG_GENIO_OUT: w = {2'b00, m_genio_out};
			`REG_GENIO_OE:  w = {2'b00, m_genio_oe};
			`REG_GPEXT_IN: begin
				w = (word_t'(vbus_det) << `GPEXT_VDET_BIT) |
					(word_t'(pmod_in) << `GPEXT_PMOD_LSB) |
					(word_t'(sao2_in) << `GPEXT_SAO2_LSB) |
					(word_t'(sao1_in) << `GPEXT_SAO1_LSB);
			end
			`REG_GPEXT_OUT: w = m_gpext_out;
			`REG_GPEXT_OE:  w = m_gpext_oe;
			default:        w = '0;
		endcase
		return w;
	endfunction

	task automatic model_write(input reg_idx_t idx, input word_t d);
		case (idx)
			`REG_LED:       m_led = d[15:0];
			`REG_SOC_VER:   m_trace = d[0];
			`REG_FLASH_SEL: begin
				m_fsel_d = d[0];
				if (d[31:8] == `RELOAD_MAGIC) begin
					m_reload = 1'b1;
				end
			end
			`REG_GENIO_OUT: m_genio_out = d[29:0];
			`REG_GENIO_OE:  m_genio_oe = d[29:0];
			`REG_GENIO_W2S: m_genio_out = m_genio_out | d[29:0];
			`REG_GENIO_W2C: m_genio_out = m_genio_out & ~d[29:0];
			`REG_GPEXT_OUT: m_gpext_out = d & GPEXT_OUT_MASK;
			`REG_GPEXT_OE:  m_gpext_oe = d & GPEXT_OE_MASK;
			`REG_GPEXT_W2S: m_gpext_out = (m_gpext_out | d) & GPEXT_OUT_MASK;
			`REG_GPEXT_W2C: m_gpext_out = m_gpext_out & ~d;
			default: begin
			end
		endcase
	endtask

	task automatic compare_ports(input string name);
		check_val({name, "_led"}, m_led, led);
		check_val({name, "_trace"}, m_trace, trace_en);
		check_val({name, "_genio_out"}, m_genio_out, genio_out);
		check_val({name, "_genio_oe"}, m_genio_oe, genio_oe);
		check_val({name, "_pmod_out"}, m_gpext_out[`GPEXT_PMOD_LSB +: 8], pmod_out);
		check_val({name, "_sao2_out"}, m_gpext_out[`GPEXT_SAO2_LSB +: 6], sao2_out);
		check_val({name, "_sao1_out"}, m_gpext_out[`GPEXT_SAO1_LSB +: 6], sao1_out);
		check_val({name, "_irda_sd"}, m_gpext_out[`GPEXT_IRDA_BIT], irda_sd);
		check_val({name, "_pmod_oe"}, m_gpext_oe[`GPEXT_PMOD_LSB +: 8], pmod_oe);
		check_val({name, "_sao2_oe"}, m_gpext_oe[`GPEXT_SAO2_LSB +: 6], sao2_oe);
		check_val({name, "_sao1_oe"}, m_gpext_oe[`GPEXT_SAO1_LSB +: 6], sao1_oe);
		check_val({name, "_fsel_d"}, m_fsel_d, fsel_d);
	endtask

	// ------------------------------
	// bus transfers
	// ------------------------------
	// random filler in the address bits the block ignores
	function automatic word_t misc_addr(input reg_idx_t idx);
		word_t a;
		a = $urandom;
		a[31:28] = `MISC_REGION;
		a[6:2] = idx;
		return a;
	endfunction

	// one four-phase transfer that ends on the falling edge after ack drops
	task automatic run_xfer(input word_t addr, input logic wr, input word_t wdata,
			output bus_rsp_t got);
		int waited;
		waited = 0;
		@(negedge clk48m);
		req_data.addr = addr;
		req_data.wdata = wdata;
		req_data.strb = strb_t'($urandom);
		req_data.strb[0] = wr;
		req_i = 1'b1;
		xfer_start = cyc;
		while (!ack && waited < ACK_WAIT) begin
			@(negedge clk48m);
			waited++;
		end
		got = rsp;
		if (!ack) begin
			errors++;
			$display("DUT gave no ack within %0d cycles for address %h", ACK_WAIT, addr);
		end else begin
			check_val("ack_rise_edge", 4, cyc - xfer_start);
		end
		req_i = 1'b0;
		waited = 0;
		while (ack && waited < ACK_WAIT) begin
			@(negedge clk48m);
			waited++;
		end
		if (ack) begin
			errors++;
			$display("ack stayed high after the request was dropped");
		end else begin
			check_val("ack_fall_edge", 5, cyc - xfer_start);
		end
	endtask

	task automatic write_reg(input reg_idx_t idx, input word_t d);
		bus_rsp_t got;
		run_xfer(misc_addr(idx), 1'b1, d, got);
		check_val("write_err_flag", 0, got.err);
		model_write(idx, d);
	endtask

	task automatic read_reg(input string name, input reg_idx_t idx);
		bus_rsp_t got;
		run_xfer(misc_addr(idx), 1'b0, $urandom, got);
		check_val(name, model_read(idx), got.rdata);
		check_val({name, "_err_flag"}, 0, got.err);
	endtask

	task automatic drive_inputs();
		@(negedge clk48m);
		btn = 8'($urandom);
		genio_in = genio_t'($urandom);
		pmod_in = pmod_t'($urandom);
		sao1_in = sao_t'($urandom);
		sao2_in = sao_t'($urandom);
		vbus_det = 1'($urandom);
	endtask

	// follows the sequencer after the transfer with edges counted from the request
	task automatic flash_write(input word_t d);
		bus_rsp_t got;
		int k;
		run_xfer(misc_addr(`REG_FLASH_SEL), 1'b1, d, got);
		check_val("fsel_err_flag", 0, got.err);
		model_write(`REG_FLASH_SEL, d);
		for (k = cyc - xfer_start; k <= 10; k++) begin
			check_val("fsel_c_pulse", (k >= 6 && k <= 8), fsel_c);
			check_val("programn_level", !(m_reload && k >= 9), programn);
			@(negedge clk48m);
		end
		compare_ports("flash_ports");
	endtask

	initial begin
		#(CLK_PERIOD * (RST_CYCLES + N_XFERS * XFER_BOUND));
		$display("watchdog expired, the run took longer than %0d transfers", N_XFERS);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int i;
		int a_errs;
		reg_idx_t idx;
		region_t region;
		word_t d;
		word_t addr;
		bus_rsp_t got;
		rst = 1'b1;
		req_i = 1'b0;
		req_data = '0;
		btn = '0;
		genio_in = '0;
		pmod_in = '0;
		sao1_in = '0;
		sao2_in = '0;
		vbus_det = 1'b0;
		void'($urandom(32'ha2ae0004));
		m_led = '0;
		m_trace = 1'b0;
		m_fsel_d = 1'b0;
		m_reload = 1'b0;
		m_genio_out = '0;
		m_genio_oe = '0;
		m_gpext_out = 32'h1 << `GPEXT_IRDA_BIT;
		m_gpext_oe = '0;
		repeat (RST_CYCLES) @(negedge clk48m);
		rst = 1'b0;

		// reset values
		compare_ports("reset");
		check_val("reset_ack", 0, ack);
		check_val("reset_programn", 1, programn);
		check_val("reset_fsel_c", 0, fsel_c);
		for (i = 0; i < 10; i++) begin
			read_reg("reset_read", READ_REGS[i]);
		end

		// plain writes with readback
		for (i = 0; i < N_RAND; i++) begin
			idx = PLAIN_REGS[$urandom_range(5, 0)];
			write_reg(idx, $urandom);
			compare_ports("plain_ports");
			read_reg("plain_read", idx);
		end

		// set and clear writes read back through the output register
		for (i = 0; i < N_RAND; i++) begin
			idx = SETCLR_REGS[$urandom_range(3, 0)];
			write_reg(idx, $urandom);
			compare_ports("setclr_ports");
			if (idx == `REG_GENIO_W2S || idx == `REG_GENIO_W2C) begin
				read_reg("setclr_genio", `REG_GENIO_OUT);
			end else begin
				read_reg("setclr_gpext", `REG_GPEXT_OUT);
			end
		end

		// inputs
		for (i = 0; i < N_INPUT; i++) begin
			drive_inputs();
			read_reg("btn_read", `REG_BTN);
			read_reg("genio_in_read", `REG_GENIO_IN);
			read_reg("gpext_in_read", `REG_GPEXT_IN);
		end

		// accesses outside the misc region
		for (i = 0; i < N_BUS_ERR; i++) begin
			do begin
				region = region_t'($urandom);
			end while (region == `MISC_REGION);
			addr = $urandom;
			addr[31:28] = region;
			run_xfer(addr, 1'($urandom), $urandom, got);
			check_val("bus_err_data", `BUS_ERR_DATA, got.rdata);
			check_val("bus_err_flag", 1, got.err);
			compare_ports("bus_err_ports");
		end
		for (i = 0; i < N_UNMAPPED; i++) begin
			do begin
				idx = reg_idx_t'($urandom);
			end while (idx inside {`REG_LED, `REG_BTN, `REG_SOC_VER, `REG_FLASH_SEL,
				`REG_GENIO_IN, `REG_GENIO_OUT, `REG_GENIO_OE, `REG_GENIO_W2S, `REG_GENIO_W2C,
				`REG_GPEXT_IN, `REG_GPEXT_OUT, `REG_GPEXT_OE, `REG_GPEXT_W2S, `REG_GPEXT_W2C});
			write_reg(idx, $urandom);
			compare_ports("unmapped_ports");
			read_reg("unmapped_read", idx);
		end

		// flash select with non-magic writes first and the reload last
		for (i = 0; i < N_FSEL; i++) begin
			do begin
				d = $urandom;
			end while (d[31:8] == `RELOAD_MAGIC);
			flash_write(d);
			read_reg("fsel_read", `REG_FLASH_SEL);
		end
		flash_write({`RELOAD_MAGIC, 8'($urandom)});
		read_reg("fsel_magic_read", `REG_FLASH_SEL);
		read_reg("after_reload_read", `REG_LED);
		check_val("programn_held", 0, programn);

		a_errs = u_dut.u_asserts.fail_cnt;
		$display("checks %0d, value errors %0d, assertion failures %0d",
			checks, errors, a_errs);
		if (errors == 0 && a_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* soc_misc.f */
+incdir+rtl
rtl/soc_misc_pkg.sv
rtl/bus_slave_port.sv
rtl/addr_decode.sv
rtl/misc_regs.sv
rtl/flash_reload_seq.sv
rtl/soc_misc_top.sv
sim/soc_misc_asserts.sv
sim/tb_soc_misc.sv
